// File: fsync_defs.svh
//****************************************
// Width and size macros of the 2x2 barrier network.
// Include this file wherever the macros are needed.
//****************************************

`ifndef FSYNC_DEFS_SVH
`define FSYNC_DEFS_SVH

// Width of a barrier id.
`define FSYNC_ID_W 2

// Number of barrier ids, one table entry per id.
`define FSYNC_N_IDS (1 << `FSYNC_ID_W)

// Aggregation width at the CU ports.
// Each level strips one bit on the way up.
`define FSYNC_AGGR_W 3

// Width of the level carried by a wake.
`define FSYNC_LVL_W 2

// Number of compute units in the grid.
`define FSYNC_N_CU 4

`endif

// File: fsync_pkg.sv
//****************************************
// Shared vector types of the barrier network.
// Imported by every RTL module of the design.
//****************************************

`default_nettype none

`include "fsync_defs.svh"

package fsync_pkg;

  // Barrier id, also the index into every per-id table.
  typedef logic [`FSYNC_ID_W-1:0] fsync_id_t;

  // Level of the node at which a barrier completed.
  typedef logic [`FSYNC_LVL_W-1:0] fsync_lvl_t;

  // Aggregation as sent by a CU.
  // Narrower copies inside the tree use the AGGR_W node parameter.
  typedef logic [`FSYNC_AGGR_W-1:0] fsync_aggr_t;

  // One bit per CU, for sync and wake vectors.
  typedef logic [`FSYNC_N_CU-1:0] fsync_cu_mask_t;

endpackage : fsync_pkg

`default_nettype wire

// File: fsync_pair_table.sv
//****************************************
// Per-id arrival table of one node.
// Pairs the requests of two children and decodes completions.
//****************************************

`timescale 1ns/10ps
`default_nettype none

`include "fsync_defs.svh"

module fsync_pair_table
  import fsync_pkg::*;
#(
  parameter int unsigned AGGR_W = `FSYNC_AGGR_W
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                a_sync_i,
  input  logic [AGGR_W-1:0]                   a_aggr_i,
  input  fsync_id_t                           a_id_i,
  input  logic                                b_sync_i,
  input  logic [AGGR_W-1:0]                   b_aggr_i,
  input  fsync_id_t                           b_id_i,
  output logic [`FSYNC_N_IDS-1:0]             done_local_o,
  output logic [`FSYNC_N_IDS-1:0]             done_fwd_o,
  output logic [`FSYNC_N_IDS-1:0][AGGR_W-2:0] fwd_aggr_o
);

  // One child waits on this id.
  logic [`FSYNC_N_IDS-1:0]             pend_q;
  // Set when child b was the first to arrive.
  logic [`FSYNC_N_IDS-1:0]             side_q;
  // Aggregation of the first arrival.
  logic [`FSYNC_N_IDS-1:0][AGGR_W-1:0] aggr_q;

  logic [`FSYNC_N_IDS-1:0]             a_hit;
  logic [`FSYNC_N_IDS-1:0]             b_hit;
  logic [`FSYNC_N_IDS-1:0]             match;
  logic [`FSYNC_N_IDS-1:0][AGGR_W-1:0] in_aggr;
  logic [`FSYNC_N_IDS-1:0][AGGR_W-1:0] pair_aggr;

  // Decode arrivals per id.
  // A pair closes when both arrive together or the partner already waits.
  always_comb begin
    for (int i = 0; i < `FSYNC_N_IDS; i++) begin
      a_hit[i]     = a_sync_i && (a_id_i == fsync_id_t'(i));
      b_hit[i]     = b_sync_i && (b_id_i == fsync_id_t'(i));
      in_aggr[i]   = a_hit[i] ? a_aggr_i : b_aggr_i;
      match[i]     = (a_hit[i] && b_hit[i]) || (pend_q[i] && (a_hit[i] || b_hit[i]));
      pair_aggr[i] = pend_q[i] ? aggr_q[i] : in_aggr[i];
      // Bit 0 set means the barrier ends at this node.
      done_local_o[i] = match[i] && pair_aggr[i][0];
      done_fwd_o[i]   = match[i] && !pair_aggr[i][0];
      // The parent sees the aggregation one level down.
      fwd_aggr_o[i]   = pair_aggr[i][AGGR_W-1:1];
    end
  end

  // Entry state.
  // A match frees the id, a lone arrival claims it.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q <= '0;
      side_q <= '0;
    end else begin
      for (int i = 0; i < `FSYNC_N_IDS; i++) begin
        if (match[i]) begin
          pend_q[i] <= 1'b0;
        end else if (a_hit[i] || b_hit[i]) begin
          pend_q[i] <= 1'b1;
          side_q[i] <= b_hit[i];
        end
      end
    end
  end

  // Aggregation store, written on the first arrival only.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `FSYNC_N_IDS; i++) begin
      if ((a_hit[i] || b_hit[i]) && !pend_q[i]) begin
        aggr_q[i] <= in_aggr[i];
      end
    end
  end

  for (genvar g = 0; g < `FSYNC_N_IDS; g++) begin : gen_chk
    // The waiting child does not send the same id a second time.
    a_no_rearrive : assert property (@(posedge clk_i) disable iff (reset_i)
      pend_q[g] |-> !(side_q[g] ? b_hit[g] : a_hit[g]));

    // The late partner agrees with the stored aggregation.
    a_aggr_late_eq : assert property (@(posedge clk_i) disable iff (reset_i)
      (pend_q[g] && (a_hit[g] || b_hit[g])) |-> (in_aggr[g] == aggr_q[g]));

    // Partners arriving together agree as well.
    a_aggr_same_eq : assert property (@(posedge clk_i) disable iff (reset_i)
      (a_hit[g] && b_hit[g]) |-> (a_aggr_i == b_aggr_i));
  end

  // A zero aggregation would climb past the root.
  a_aggr_nonzero : assert property (@(posedge clk_i) disable iff (reset_i)
    !(a_sync_i && (a_aggr_i == '0)) && !(b_sync_i && (b_aggr_i == '0)));

endmodule : fsync_pair_table

`default_nettype wire

// File: fsync_id_queue.sv
//****************************************
// Per-id pending bits that put one item per cycle on an output.
// A pass-through item takes the output before any pending id.
//****************************************

`timescale 1ns/10ps
`default_nettype none

`include "fsync_defs.svh"

module fsync_id_queue
  import fsync_pkg::*;
#(
  parameter int unsigned PAYLOAD_W = `FSYNC_LVL_W
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic [`FSYNC_N_IDS-1:0]                set_i,
  input  logic [`FSYNC_N_IDS-1:0][PAYLOAD_W-1:0] set_payload_i,
  input  logic                                   pass_valid_i,
  input  fsync_id_t                              pass_id_i,
  input  logic [PAYLOAD_W-1:0]                   pass_payload_i,
  output logic                                   out_valid_o,
  output fsync_id_t                              out_id_o,
  output logic [PAYLOAD_W-1:0]                   out_payload_o
);

  logic [`FSYNC_N_IDS-1:0]                pend_q;
  logic [`FSYNC_N_IDS-1:0][PAYLOAD_W-1:0] pay_q;

  logic [`FSYNC_N_IDS-1:0]                cand;
  logic [`FSYNC_N_IDS-1:0][PAYLOAD_W-1:0] cand_pay;
  logic [`FSYNC_N_IDS-1:0]                grant;
  logic                                   sel_found;
  fsync_id_t                              sel_id;

  // New sets compete in the same cycle, so an idle port adds no delay.
  always_comb begin
    cand      = pend_q | set_i;
    sel_found = 1'b0;
    sel_id    = '0;
    // Scan downward, so the lowest pending id wins.
    for (int i = `FSYNC_N_IDS - 1; i >= 0; i--) begin
      cand_pay[i] = set_i[i] ? set_payload_i[i] : pay_q[i];
      if (cand[i]) begin
        sel_found = 1'b1;
        sel_id    = fsync_id_t'(i);
      end
    end
    grant = '0;
    if (!pass_valid_i && sel_found) begin
      grant[sel_id] = 1'b1;
    end
  end

  // Pending ids stay until granted.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q      <= '0;
      out_valid_o <= 1'b0;
    end else begin
      pend_q      <= cand & ~grant;
      out_valid_o <= pass_valid_i || sel_found;
    end
  end

  // Payload per id, and the registered output item.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `FSYNC_N_IDS; i++) begin
      if (set_i[i]) begin
        pay_q[i] <= set_payload_i[i];
      end
    end
    if (pass_valid_i) begin
      out_id_o      <= pass_id_i;
      out_payload_o <= pass_payload_i;
    end else begin
      out_id_o      <= sel_id;
      out_payload_o <= cand_pay[sel_id];
    end
  end

  // An id completes again only after its previous item has left.
  a_set_free : assert property (@(posedge clk_i) disable iff (reset_i)
    (set_i & pend_q) == '0);

endmodule : fsync_id_queue

`default_nettype wire

// File: fsync_pair_node.sv
//****************************************
// One barrier node joining two children.
// Completes locally or forwards up, and relays wakes from above.
//****************************************

`timescale 1ns/10ps
`default_nettype none

`include "fsync_defs.svh"

module fsync_pair_node
  import fsync_pkg::*;
#(
  parameter int unsigned LEVEL  = 0,
  parameter int unsigned AGGR_W = `FSYNC_AGGR_W
) (
  input  logic              clk_i,
  input  logic              reset_i,
  // Child requests.
  input  logic              a_sync_i,
  input  logic [AGGR_W-1:0] a_aggr_i,
  input  fsync_id_t         a_id_i,
  input  logic              b_sync_i,
  input  logic [AGGR_W-1:0] b_aggr_i,
  input  fsync_id_t         b_id_i,
  // Wake shared by both children.
  output logic              wake_o,
  output fsync_lvl_t        lvl_o,
  output fsync_id_t         id_o,
  // Parent side.
  output logic              up_sync_o,
  output logic [AGGR_W-2:0] up_aggr_o,
  output fsync_id_t         up_id_o,
  input  logic              up_wake_i,
  input  fsync_lvl_t        up_lvl_i,
  input  fsync_id_t         up_id_i
);

  logic [`FSYNC_N_IDS-1:0]                  done_local;
  logic [`FSYNC_N_IDS-1:0]                  done_fwd;
  logic [`FSYNC_N_IDS-1:0][AGGR_W-2:0]      fwd_aggr;
  logic [`FSYNC_N_IDS-1:0][`FSYNC_LVL_W-1:0] local_lvl;

  // Local completions report this node's level.
  assign local_lvl = {`FSYNC_N_IDS{fsync_lvl_t'(LEVEL)}};

  fsync_pair_table #(
    .AGGR_W (AGGR_W)
  ) u_table (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .a_sync_i     (a_sync_i),
    .a_aggr_i     (a_aggr_i),
    .a_id_i       (a_id_i),
    .b_sync_i     (b_sync_i),
    .b_aggr_i     (b_aggr_i),
    .b_id_i       (b_id_i),
    .done_local_o (done_local),
    .done_fwd_o   (done_fwd),
    .fwd_aggr_o   (fwd_aggr)
  );

  // Downward queue.
  // Wakes from above go straight through and hold off local wakes.
  fsync_id_queue #(
    .PAYLOAD_W (`FSYNC_LVL_W)
  ) u_wake_q (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .set_i          (done_local),
    .set_payload_i  (local_lvl),
    .pass_valid_i   (up_wake_i),
    .pass_id_i      (up_id_i),
    .pass_payload_i (up_lvl_i),
    .out_valid_o    (wake_o),
    .out_id_o       (id_o),
    .out_payload_o  (lvl_o)
  );

  // Upward queue, carrying the shifted aggregation.
  // Nothing passes through on this side.
  fsync_id_queue #(
    .PAYLOAD_W (AGGR_W - 1)
  ) u_fwd_q (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .set_i          (done_fwd),
    .set_payload_i  (fwd_aggr),
    .pass_valid_i   (1'b0),
    .pass_id_i      ('0),
    .pass_payload_i ('0),
    .out_valid_o    (up_sync_o),
    .out_id_o       (up_id_o),
    .out_payload_o  (up_aggr_o)
  );

endmodule : fsync_pair_node

`default_nettype wire

// File: fsync_2x2.sv
//****************************************
// Top of the 2x2 barrier network.
// Rows and columns each get two level-0 nodes under one level-1 node.
//****************************************

`timescale 1ns/10ps
`default_nettype none

`include "fsync_defs.svh"

module fsync_2x2
  import fsync_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             reset_i,
  // Horizontal CU ports.
  input  fsync_cu_mask_t                   h_sync_i,
  input  fsync_aggr_t [`FSYNC_N_CU-1:0]    h_aggr_i,
  input  fsync_id_t   [`FSYNC_N_CU-1:0]    h_id_i,
  output fsync_cu_mask_t                   h_wake_o,
  output fsync_lvl_t  [`FSYNC_N_CU-1:0]    h_lvl_o,
  output fsync_id_t   [`FSYNC_N_CU-1:0]    h_id_o,
  // Vertical CU ports.
  input  fsync_cu_mask_t                   v_sync_i,
  input  fsync_aggr_t [`FSYNC_N_CU-1:0]    v_aggr_i,
  input  fsync_id_t   [`FSYNC_N_CU-1:0]    v_id_i,
  output fsync_cu_mask_t                   v_wake_o,
  output fsync_lvl_t  [`FSYNC_N_CU-1:0]    v_lvl_o,
  output fsync_id_t   [`FSYNC_N_CU-1:0]    v_id_o,
  // Horizontal upward port.
  output logic                             h_up_sync_o,
  output logic [`FSYNC_AGGR_W-3:0]         h_up_aggr_o,
  output fsync_id_t                        h_up_id_o,
  input  logic                             h_up_wake_i,
  input  fsync_lvl_t                       h_up_lvl_i,
  input  fsync_id_t                        h_up_id_i,
  // Vertical upward port.
  output logic                             v_up_sync_o,
  output logic [`FSYNC_AGGR_W-3:0]         v_up_aggr_o,
  output fsync_id_t                        v_up_id_o,
  input  logic                             v_up_wake_i,
  input  fsync_lvl_t                       v_up_lvl_i,
  input  fsync_id_t                        v_up_id_i
);

  // Aggregation width between level 0 and level 1.
  localparam int unsigned L1_AGGR_W = `FSYNC_AGGR_W - 1;

  // Direction index 0 is horizontal, 1 is vertical.
  fsync_cu_mask_t                cu_sync [2];
  fsync_aggr_t [`FSYNC_N_CU-1:0] cu_aggr [2];
  fsync_id_t   [`FSYNC_N_CU-1:0] cu_id   [2];
  fsync_cu_mask_t                cu_wake [2];
  fsync_lvl_t  [`FSYNC_N_CU-1:0] cu_lvl  [2];
  fsync_id_t   [`FSYNC_N_CU-1:0] cu_wid  [2];

  // Level-0 node outputs, by direction and node.
  logic                 l0_wake    [2][2];
  fsync_lvl_t           l0_lvl     [2][2];
  fsync_id_t            l0_id      [2][2];
  logic                 l0_up_sync [2][2];
  logic [L1_AGGR_W-1:0] l0_up_aggr [2][2];
  fsync_id_t            l0_up_id   [2][2];

  // Level-1 wakes back to level 0, and the upward ports.
  logic                 l1_wake [2];
  fsync_lvl_t           l1_lvl  [2];
  fsync_id_t            l1_id   [2];
  logic                 up_sync [2];
  logic [L1_AGGR_W-2:0] up_aggr [2];
  fsync_id_t            up_id   [2];
  logic                 up_wake [2];
  fsync_lvl_t           up_lvl  [2];
  fsync_id_t            up_wid  [2];

  assign cu_sync[0] = h_sync_i;
  assign cu_aggr[0] = h_aggr_i;
  assign cu_id[0]   = h_id_i;
  assign cu_sync[1] = v_sync_i;
  assign cu_aggr[1] = v_aggr_i;
  assign cu_id[1]   = v_id_i;

  assign h_wake_o = cu_wake[0];
  assign h_lvl_o  = cu_lvl[0];
  assign h_id_o   = cu_wid[0];
  assign v_wake_o = cu_wake[1];
  assign v_lvl_o  = cu_lvl[1];
  assign v_id_o   = cu_wid[1];

  assign h_up_sync_o = up_sync[0];
  assign h_up_aggr_o = up_aggr[0];
  assign h_up_id_o   = up_id[0];
  assign v_up_sync_o = up_sync[1];
  assign v_up_aggr_o = up_aggr[1];
  assign v_up_id_o   = up_id[1];

  assign up_wake[0] = h_up_wake_i;
  assign up_lvl[0]  = h_up_lvl_i;
  assign up_wid[0]  = h_up_id_i;
  assign up_wake[1] = v_up_wake_i;
  assign up_lvl[1]  = v_up_lvl_i;
  assign up_wid[1]  = v_up_id_i;

  for (genvar d = 0; d < 2; d++) begin : gen_dir
    for (genvar n = 0; n < 2; n++) begin : gen_l0
      // Rows pair CUs 2n and 2n+1.
      // Columns pair n and n+2, which is the transpose.
      localparam int unsigned CU_A = (d == 0) ? 2 * n : n;
      localparam int unsigned CU_B = (d == 0) ? 2 * n + 1 : n + 2;

      fsync_pair_node #(
        .LEVEL  (0),
        .AGGR_W (`FSYNC_AGGR_W)
      ) u_l0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .a_sync_i  (cu_sync[d][CU_A]),
        .a_aggr_i  (cu_aggr[d][CU_A]),
        .a_id_i    (cu_id[d][CU_A]),
        .b_sync_i  (cu_sync[d][CU_B]),
        .b_aggr_i  (cu_aggr[d][CU_B]),
        .b_id_i    (cu_id[d][CU_B]),
        .wake_o    (l0_wake[d][n]),
        .lvl_o     (l0_lvl[d][n]),
        .id_o      (l0_id[d][n]),
        .up_sync_o (l0_up_sync[d][n]),
        .up_aggr_o (l0_up_aggr[d][n]),
        .up_id_o   (l0_up_id[d][n]),
        .up_wake_i (l1_wake[d]),
        .up_lvl_i  (l1_lvl[d]),
        .up_id_i   (l1_id[d])
      );
    end

    // Level 1 joins the two level-0 nodes of one direction.
    fsync_pair_node #(
      .LEVEL  (1),
      .AGGR_W (L1_AGGR_W)
    ) u_l1 (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .a_sync_i  (l0_up_sync[d][0]),
      .a_aggr_i  (l0_up_aggr[d][0]),
      .a_id_i    (l0_up_id[d][0]),
      .b_sync_i  (l0_up_sync[d][1]),
      .b_aggr_i  (l0_up_aggr[d][1]),
      .b_id_i    (l0_up_id[d][1]),
      .wake_o    (l1_wake[d]),
      .lvl_o     (l1_lvl[d]),
      .id_o      (l1_id[d]),
      .up_sync_o (up_sync[d]),
      .up_aggr_o (up_aggr[d]),
      .up_id_o   (up_id[d]),
      .up_wake_i (up_wake[d]),
      .up_lvl_i  (up_lvl[d]),
      .up_id_i   (up_wid[d])
    );

    // Each node wake fans out to both of its CUs.
    for (genvar c = 0; c < `FSYNC_N_CU; c++) begin : gen_fan
      localparam int unsigned NODE = (d == 0) ? c / 2 : c % 2;

      assign cu_wake[d][c] = l0_wake[d][NODE];
      assign cu_lvl[d][c]  = l0_lvl[d][NODE];
      assign cu_wid[d][c]  = l0_id[d][NODE];
    end
  end

endmodule : fsync_2x2

`default_nettype wire

// File: tb_fsync_clkgen.sv
//****************************************
// Testbench clock and reset source.
// 8 ns clock, reset held high for the first two rising edges.
//****************************************

`timescale 1ns/10ps
`default_nettype none

module tb_fsync_clkgen (
  output logic clk_o,
  output logic reset_o
);

  // Free-running clock, half period of 4 ns.
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset drops on the second rising edge.
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule : tb_fsync_clkgen

`default_nettype wire

// File: tb_fsync_2x2.sv
//****************************************
// Table-driven testbench of the 2x2 barrier network.
// Runs fixed steps, then random concurrent barriers, and prints a verdict.
//****************************************

`timescale 1ns/10ps
`default_nettype none

`include "fsync_defs.svh"

module tb_fsync_2x2
  import fsync_pkg::*;
();

  // One table row: a barrier and its expected outcome.
  typedef struct packed {
    logic                   dir;
    logic [`FSYNC_N_CU-1:0] cu_mask;
    fsync_aggr_t            aggr;
    fsync_id_t              id;
    logic [`FSYNC_N_CU-1:0] exp_mask;
    fsync_lvl_t             exp_lvl;
    logic                   exp_up;
  } step_t;

  // One CU request of the random phase.
  typedef struct packed {
    logic        dir;
    logic [1:0]  cu;
    fsync_aggr_t aggr;
    fsync_id_t   id;
  } req_t;

  localparam int N_STEPS    = 12;
  localparam int WAIT_LIMIT = 40;
  localparam int SETTLE     = 6;

  logic                          clk;
  logic                          reset;
  fsync_cu_mask_t                h_sync;
  fsync_cu_mask_t                v_sync;
  fsync_aggr_t [`FSYNC_N_CU-1:0] h_aggr;
  fsync_aggr_t [`FSYNC_N_CU-1:0] v_aggr;
  fsync_id_t   [`FSYNC_N_CU-1:0] h_id;
  fsync_id_t   [`FSYNC_N_CU-1:0] v_id;
  fsync_cu_mask_t                h_wake;
  fsync_cu_mask_t                v_wake;
  fsync_lvl_t  [`FSYNC_N_CU-1:0] h_lvl;
  fsync_lvl_t  [`FSYNC_N_CU-1:0] v_lvl;
  fsync_id_t   [`FSYNC_N_CU-1:0] h_wid;
  fsync_id_t   [`FSYNC_N_CU-1:0] v_wid;
  logic                          h_up_sync;
  logic                          v_up_sync;
  logic [`FSYNC_AGGR_W-3:0]      h_up_aggr;
  logic [`FSYNC_AGGR_W-3:0]      v_up_aggr;
  fsync_id_t                     h_up_id;
  fsync_id_t                     v_up_id;
  logic                          h_up_wake;
  logic                          v_up_wake;
  fsync_lvl_t                    h_up_lvl;
  fsync_lvl_t                    v_up_lvl;
  fsync_id_t                     h_up_wid;
  fsync_id_t                     v_up_wid;

  // Wake counts and last levels seen per side, CU and id.
  int         wake_cnt [2][`FSYNC_N_CU][`FSYNC_N_IDS] = '{default: 0};
  fsync_lvl_t wake_lvl [2][`FSYNC_N_CU][`FSYNC_N_IDS];
  int         up_cnt   [2][`FSYNC_N_IDS] = '{default: 0};
  logic [`FSYNC_AGGR_W-3:0] up_aggr_seen [2][`FSYNC_N_IDS];

  // Expected counts per step count from the base snapshot.
  int         base_cnt [2][`FSYNC_N_CU][`FSYNC_N_IDS];
  int         exp_cnt  [2][`FSYNC_N_CU][`FSYNC_N_IDS];
  fsync_lvl_t exp_lvl  [2][`FSYNC_N_CU][`FSYNC_N_IDS];
  int         base_up  [2][`FSYNC_N_IDS];
  int         exp_up   [2][`FSYNC_N_IDS];

  // Requests staged for the next rising edge.
  // Index 0 is horizontal.
  logic        [1:0][`FSYNC_N_CU-1:0] st_sync;
  fsync_aggr_t [1:0][`FSYNC_N_CU-1:0] st_aggr;
  fsync_id_t   [1:0][`FSYNC_N_CU-1:0] st_id;

  step_t steps [N_STEPS];
  int    checks;
  int    errors;
  int    timeouts;
  int    seed;

  tb_fsync_clkgen u_clkgen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  fsync_2x2 UUT (
    .clk_i       (clk),
    .reset_i     (reset),
    .h_sync_i    (h_sync),
    .h_aggr_i    (h_aggr),
    .h_id_i      (h_id),
    .h_wake_o    (h_wake),
    .h_lvl_o     (h_lvl),
    .h_id_o      (h_wid),
    .v_sync_i    (v_sync),
    .v_aggr_i    (v_aggr),
    .v_id_i      (v_id),
    .v_wake_o    (v_wake),
    .v_lvl_o     (v_lvl),
    .v_id_o      (v_wid),
    .h_up_sync_o (h_up_sync),
    .h_up_aggr_o (h_up_aggr),
    .h_up_id_o   (h_up_id),
    .h_up_wake_i (h_up_wake),
    .h_up_lvl_i  (h_up_lvl),
    .h_up_id_i   (h_up_wid),
    .v_up_sync_o (v_up_sync),
    .v_up_aggr_o (v_up_aggr),
    .v_up_id_o   (v_up_id),
    .v_up_wake_i (v_up_wake),
    .v_up_lvl_i  (v_up_lvl),
    .v_up_id_i   (v_up_wid)
  );

  // Wake and upward request collector.
  // Outputs settle after the rising edge, so the falling edge is safe.
  always @(negedge clk) begin
    if (!reset) begin
      for (int c = 0; c < `FSYNC_N_CU; c++) begin
        if (h_wake[c]) begin
          wake_cnt[0][c][h_wid[c]] += 1;
          wake_lvl[0][c][h_wid[c]] = h_lvl[c];
        end
        if (v_wake[c]) begin
          wake_cnt[1][c][v_wid[c]] += 1;
          wake_lvl[1][c][v_wid[c]] = v_lvl[c];
        end
      end
      if (h_up_sync) begin
        up_cnt[0][h_up_id] += 1;
        up_aggr_seen[0][h_up_id] = h_up_aggr;
      end
      if (v_up_sync) begin
        up_cnt[1][v_up_id] += 1;
        up_aggr_seen[1][v_up_id] = v_up_aggr;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // CUs of level-0 pair k in the grid.
  // Rows are CUs 0 and 1, then 2 and 3.
  // Columns are CUs 0 and 2, then 1 and 3.
  function automatic logic [`FSYNC_N_CU-1:0] pair_mask(input int d, input int k);
    logic [`FSYNC_N_CU-1:0] m;
    if (d == 0) begin
      m = (k == 0) ? 4'b0011 : 4'b1100;
    end else begin
      m = (k == 0) ? 4'b0101 : 4'b1010;
    end
    return m;
  endfunction

  // Snapshot the collector and clear all expectations.
  task automatic clear_expect();
    for (int d = 0; d < 2; d++) begin
      for (int i = 0; i < `FSYNC_N_IDS; i++) begin
        for (int c = 0; c < `FSYNC_N_CU; c++) begin
          base_cnt[d][c][i] = wake_cnt[d][c][i];
          exp_cnt[d][c][i]  = 0;
          exp_lvl[d][c][i]  = '0;
        end
        base_up[d][i] = up_cnt[d][i];
        exp_up[d][i]  = 0;
      end
    end
  endtask

  function automatic bit wakes_complete();
    for (int d = 0; d < 2; d++) begin
      for (int c = 0; c < `FSYNC_N_CU; c++) begin
        for (int i = 0; i < `FSYNC_N_IDS; i++) begin
          if (wake_cnt[d][c][i] - base_cnt[d][c][i] < exp_cnt[d][c][i]) begin
            return 1'b0;
          end
        end
      end
    end
    return 1'b1;
  endfunction

  task automatic stage_req(input logic d, input logic [1:0] c,
                           input fsync_aggr_t aggr, input fsync_id_t id);
    st_sync[d][c] = 1'b1;
    st_aggr[d][c] = aggr;
    st_id[d][c]   = id;
  endtask

  // Drive the staged requests for one cycle.
  task automatic apply_stage();
    @(posedge clk);
    h_sync <= st_sync[0];
    h_aggr <= st_aggr[0];
    h_id   <= st_id[0];
    v_sync <= st_sync[1];
    v_aggr <= st_aggr[1];
    v_id   <= st_id[1];
    st_sync = '0;
  endtask

  task automatic drive_up_wake(input logic d, input fsync_lvl_t lvl, input fsync_id_t id);
    @(posedge clk);
    if (d == 1'b0) begin
      h_up_wake <= 1'b1;
      h_up_lvl  <= lvl;
      h_up_wid  <= id;
    end else begin
      v_up_wake <= 1'b1;
      v_up_lvl  <= lvl;
      v_up_wid  <= id;
    end
    @(posedge clk);
    h_up_wake <= 1'b0;
    v_up_wake <= 1'b0;
  endtask

  task automatic wait_wakes(input int limit);
    int n;
    n = 0;
    while (!wakes_complete() && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!wakes_complete()) begin
      timeouts++;
      $display("Timeout: expected wakes did not arrive within %0d cycles", limit);
    end
  endtask

  task automatic wait_upward(input logic d, input fsync_id_t id);
    int n;
    n = 0;
    while (up_cnt[d][id] - base_up[d][id] < 1 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (up_cnt[d][id] - base_up[d][id] < 1) begin
      timeouts++;
      $display("Timeout: no upward request on side %0d for id %0d", d, id);
    end
  endtask

  // Every wake is counted exactly as expected and with the right level.
  task automatic compare_all();
    string side;
    int    seen;
    for (int d = 0; d < 2; d++) begin
      side = (d == 0) ? "h" : "v";
      for (int c = 0; c < `FSYNC_N_CU; c++) begin
        for (int i = 0; i < `FSYNC_N_IDS; i++) begin
          seen = wake_cnt[d][c][i] - base_cnt[d][c][i];
          check_value($sformatf("%s_wake_o[%0d] id %0d count", side, c, i),
                      seen, exp_cnt[d][c][i]);
          if (seen > 0 && exp_cnt[d][c][i] > 0) begin
            check_value($sformatf("%s_lvl_o[%0d] id %0d", side, c, i),
                        32'(wake_lvl[d][c][i]), 32'(exp_lvl[d][c][i]));
          end
        end
      end
      for (int i = 0; i < `FSYNC_N_IDS; i++) begin
        check_value($sformatf("%s_up_sync_o id %0d count", side, i),
                    up_cnt[d][i] - base_up[d][i], exp_up[d][i]);
      end
    end
  endtask

  task automatic run_step(input step_t s);
    clear_expect();
    for (int c = 0; c < `FSYNC_N_CU; c++) begin
      if (s.cu_mask[c]) begin
        stage_req(s.dir, 2'(c), s.aggr, s.id);
      end
      if (s.exp_mask[c]) begin
        exp_cnt[s.dir][c][s.id] = 1;
        exp_lvl[s.dir][c][s.id] = s.exp_lvl;
      end
    end
    if (s.exp_up) begin
      exp_up[s.dir][s.id] = 1;
    end
    apply_stage();
    apply_stage();
    // A forwarded barrier needs the wake from above.
    if (s.exp_up) begin
      wait_upward(s.dir, s.id);
      check_value($sformatf("%s_up_aggr_o", s.dir ? "v" : "h"),
                  32'(up_aggr_seen[s.dir][s.id]), 32'd1);
      drive_up_wake(s.dir, s.exp_lvl, s.id);
    end
    wait_wakes(WAIT_LIMIT);
    repeat (SETTLE) @(posedge clk);
    compare_all();
  endtask

  // Per side, every id gets a random barrier kind.
  // Kind 0 and 1 are level-0 nodes and kind 2 is the level-1 node.
  task automatic run_concurrent(input int rounds);
    req_t                   reqs[$];
    req_t                   rest[$];
    req_t                   r;
    logic [7:0]             used;
    logic [`FSYNC_N_CU-1:0] mask;
    int                     kind;
    int                     j;
    int                     take;
    for (int n = 0; n < rounds; n++) begin
      clear_expect();
      reqs.delete();
      for (int d = 0; d < 2; d++) begin
        for (int i = 0; i < `FSYNC_N_IDS; i++) begin
          kind = $unsigned($random(seed)) % 3;
          mask = (kind == 2) ? 4'b1111 : pair_mask(d, kind);
          for (int c = 0; c < `FSYNC_N_CU; c++) begin
            if (mask[c]) begin
              r.dir  = 1'(d);
              r.cu   = 2'(c);
              r.aggr = (kind == 2) ? 3'b010 : 3'b001;
              r.id   = fsync_id_t'(i);
              reqs.push_back(r);
              exp_cnt[d][c][i] = 1;
              exp_lvl[d][c][i] = (kind == 2) ? 2'd1 : 2'd0;
            end
          end
        end
      end
      // Shuffle the requests.
      for (int k = reqs.size() - 1; k > 0; k--) begin
        j       = $unsigned($random(seed)) % (k + 1);
        r       = reqs[k];
        reqs[k] = reqs[j];
        reqs[j] = r;
      end
      // Each cycle sends at most one request per port and up to four in all.
      while (reqs.size() > 0) begin
        used = '0;
        rest.delete();
        take = 1 + ($unsigned($random(seed)) % 4);
        foreach (reqs[k]) begin
          if (take > 0 && !used[{reqs[k].dir, reqs[k].cu}]) begin
            stage_req(reqs[k].dir, reqs[k].cu, reqs[k].aggr, reqs[k].id);
            used[{reqs[k].dir, reqs[k].cu}] = 1'b1;
            take--;
          end else begin
            rest.push_back(reqs[k]);
          end
        end
        reqs = rest;
        apply_stage();
      end
      apply_stage();
      wait_wakes(2 * WAIT_LIMIT);
      repeat (SETTLE) @(posedge clk);
      compare_all();
    end
  endtask

  initial begin
    int n;
    h_sync    = '0;
    h_aggr    = '0;
    h_id      = '0;
    v_sync    = '0;
    v_aggr    = '0;
    v_id      = '0;
    h_up_wake = 1'b0;
    h_up_lvl  = '0;
    h_up_wid  = '0;
    v_up_wake = 1'b0;
    v_up_lvl  = '0;
    v_up_wid  = '0;
    st_sync   = '0;
    st_aggr   = '0;
    st_id     = '0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    seed      = 34;

    // Each row holds dir, CUs, aggr, id, expected wakes, lvl and upward request.
    steps[0]  = '{1'b0, 4'b0011, 3'b001, 2'd0, 4'b0011, 2'd0, 1'b0};
    steps[1]  = '{1'b0, 4'b1100, 3'b001, 2'd1, 4'b1100, 2'd0, 1'b0};
    steps[2]  = '{1'b1, 4'b0101, 3'b001, 2'd2, 4'b0101, 2'd0, 1'b0};
    steps[3]  = '{1'b1, 4'b1010, 3'b001, 2'd3, 4'b1010, 2'd0, 1'b0};
    steps[4]  = '{1'b0, 4'b1111, 3'b010, 2'd2, 4'b1111, 2'd1, 1'b0};
    steps[5]  = '{1'b1, 4'b1111, 3'b010, 2'd0, 4'b1111, 2'd1, 1'b0};
    // One row or column alone stays pending at level 1.
    steps[6]  = '{1'b0, 4'b0011, 3'b010, 2'd1, 4'b0000, 2'd0, 1'b0};
    steps[7]  = '{1'b0, 4'b1100, 3'b010, 2'd1, 4'b1111, 2'd1, 1'b0};
    steps[8]  = '{1'b1, 4'b0101, 3'b010, 2'd3, 4'b0000, 2'd0, 1'b0};
    steps[9]  = '{1'b1, 4'b1010, 3'b010, 2'd3, 4'b1111, 2'd1, 1'b0};
    steps[10] = '{1'b0, 4'b1111, 3'b100, 2'd3, 4'b1111, 2'd2, 1'b1};
    steps[11] = '{1'b1, 4'b1111, 3'b100, 2'd1, 4'b1111, 2'd2, 1'b1};

    n = 0;
    while (reset && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (reset) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end

    // Quiet outputs after reset.
    clear_expect();
    repeat (10) @(posedge clk);
    compare_all();

    for (int s = 0; s < N_STEPS; s++) begin
      run_step(steps[s]);
    end
    run_concurrent(4);

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_fsync_2x2

`default_nettype wire

// File: fsync_2x2.f
+incdir+.
fsync_pkg.sv
fsync_pair_table.sv
fsync_id_queue.sv
fsync_pair_node.sv
fsync_2x2.sv
tb_fsync_clkgen.sv
tb_fsync_2x2.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the 2x2 barrier network testbench with Verilator and run it.
# The log decides the result.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_fsync_2x2 \
  -f fsync_2x2.f \
  -o sim_fsync_2x2

./obj_dir/sim_fsync_2x2 | tee sim.log

if grep -qx "Verification passed" sim.log; then
  exit 0
fi
exit 1
